//--- include/be_defs.svh
`ifndef BE_DEFS_SVH
`define BE_DEFS_SVH

// datapath and pc width
`define BE_XLEN 32

// architectural registers, r0 reads as zero
`define BE_NUM_REGS 8
`define BE_REG_AW 3

// queue depths, each one sets the credits held by its sender
`define BE_IN_DEPTH 4
`define BE_ISS_DEPTH 2

`endif

//--- src/be_pkg.sv
`include "be_defs.svh"

package be_pkg;

  // operation encoding as delivered by the decoder
  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_addi = 3'd5,
    op_beq  = 3'd6,
    op_bne  = 3'd7
  } be_op_e;

  // instruction as it enters the backend
  typedef struct packed {
    be_op_e                 op;
    logic [`BE_REG_AW-1:0]  rd;
    logic [`BE_REG_AW-1:0]  rs1;
    logic [`BE_REG_AW-1:0]  rs2;
    logic [`BE_XLEN-1:0]    imm;
    logic [`BE_XLEN-1:0]    pc;
    logic                   pred_taken;
    logic [`BE_XLEN-1:0]    target;
  } decoded_instr_t;

  // after operand read, register indices replaced by values
  typedef struct packed {
    be_op_e                 op;
    logic [`BE_REG_AW-1:0]  rd;
    logic [`BE_XLEN-1:0]    rs1_val;
    logic [`BE_XLEN-1:0]    rs2_val;
    logic [`BE_XLEN-1:0]    imm;
    logic [`BE_XLEN-1:0]    pc;
    logic                   pred_taken;
    logic [`BE_XLEN-1:0]    target;
  } issued_instr_t;

  function automatic logic op_is_branch(input be_op_e op);
    return (op == op_beq) || (op == op_bne);
  endfunction

  // addi takes its second operand from the immediate
  function automatic logic op_uses_rs2(input be_op_e op);
    return op != op_addi;
  endfunction

endpackage

//--- src/be_credit_queue.sv
`timescale 1ns/10ps

module be_credit_queue
  #(parameter type PAYLOAD_T = logic
  , parameter int  DEPTH     = 4
  )
  (input  logic      clk_i
  , input  logic     rst_n_i
  , input  logic     flush_i
  , input  logic     push_i
  , input  PAYLOAD_T push_data_i
  , input  logic     pop_i
  , output logic     empty_o
  , output PAYLOAD_T pop_data_o
  , output logic     credit_o
  );

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  PAYLOAD_T       mem_q [DEPTH];
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [CW-1:0]  count_q;
  logic           do_push;
  logic           do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // sender holds a credit per free slot, so no full check here
  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & ~flush_i & (count_q != '0);

  assign empty_o    = (count_q == '0);
  assign pop_data_o = mem_q[rd_ptr_q];
  // one credit back per entry removed
  assign credit_o   = do_pop;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + CW'(do_push) - CW'(do_pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

//--- src/be_decode_stage.sv
`timescale 1ns/10ps
`include "be_defs.svh"

module be_decode_stage
  (input  logic                        clk_i
  , input  logic                       rst_n_i
  , input  logic                       flush_i
  // input queue head
  , input  logic                       in_empty_i
  , input  be_pkg::decoded_instr_t     in_instr_i
  , output logic                       in_pop_o
  // register file read
  , output logic [`BE_REG_AW-1:0]      rf_rs1_addr_o
  , output logic [`BE_REG_AW-1:0]      rf_rs2_addr_o
  , input  logic [`BE_XLEN-1:0]        rf_rs1_data_i
  , input  logic [`BE_XLEN-1:0]        rf_rs2_data_i
  // scoreboard release
  , input  logic                       wb_valid_i
  , input  logic [`BE_REG_AW-1:0]      wb_rd_i
  // issue queue
  , input  logic                       iss_credit_i
  , output logic                       iss_push_o
  , output be_pkg::issued_instr_t      iss_instr_o
  );

  localparam int CW = $clog2(`BE_ISS_DEPTH + 1);

  logic [`BE_NUM_REGS-1:0]  busy_q;
  logic [`BE_NUM_REGS-1:0]  release_mask;
  logic [`BE_NUM_REGS-1:0]  busy_eff;
  logic [`BE_NUM_REGS-1:0]  set_mask;
  logic [CW-1:0]            credit_q;
  logic                     writes_rd;
  logic                     hazard;
  logic                     do_pop;

  // rf is already written when the release pulse arrives, so it bypasses the busy bit
  assign release_mask = wb_valid_i ? (`BE_NUM_REGS'(1) << wb_rd_i) : '0;
  assign busy_eff     = busy_q & ~release_mask;

  assign writes_rd = ~be_pkg::op_is_branch(in_instr_i.op);

  // rd check keeps an older writer from releasing a younger one's bit
  assign hazard = busy_eff[in_instr_i.rs1]
                | (be_pkg::op_uses_rs2(in_instr_i.op) & busy_eff[in_instr_i.rs2])
                | (writes_rd & busy_eff[in_instr_i.rd]);

  assign do_pop   = ~in_empty_i & (credit_q != '0) & ~hazard & ~flush_i;
  assign in_pop_o = do_pop;

  // r0 never goes busy
  assign set_mask = (do_pop && writes_rd && in_instr_i.rd != '0)
                  ? (`BE_NUM_REGS'(1) << in_instr_i.rd) : '0;

  assign rf_rs1_addr_o = in_instr_i.rs1;
  assign rf_rs2_addr_o = in_instr_i.rs2;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
    begin
      busy_q     <= '0;
      credit_q   <= CW'(`BE_ISS_DEPTH);
      iss_push_o <= 1'b0;
    end
    else
    begin
      busy_q     <= busy_eff | set_mask;
      credit_q   <= credit_q - CW'(do_pop) + CW'(iss_credit_i);
      iss_push_o <= do_pop;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_pop)
    begin
      iss_instr_o.op         <= in_instr_i.op;
      iss_instr_o.rd         <= in_instr_i.rd;
      iss_instr_o.rs1_val    <= rf_rs1_data_i;
      iss_instr_o.rs2_val    <= rf_rs2_data_i;
      iss_instr_o.imm        <= in_instr_i.imm;
      iss_instr_o.pc         <= in_instr_i.pc;
      iss_instr_o.pred_taken <= in_instr_i.pred_taken;
      iss_instr_o.target     <= in_instr_i.target;
    end
  end

endmodule

//--- src/be_execute_stage.sv
`timescale 1ns/10ps
`include "be_defs.svh"

module be_execute_stage
  (input  logic                      clk_i
  , input  logic                     rst_n_i
  , input  logic                     flush_i
  , input  logic                     iss_empty_i
  , input  be_pkg::issued_instr_t    iss_instr_i
  , output logic                     iss_pop_o
  , output logic                     ex_valid_o
  , output logic [`BE_XLEN-1:0]      ex_pc_o
  , output logic [`BE_REG_AW-1:0]    ex_rd_o
  , output logic [`BE_XLEN-1:0]      ex_result_o
  , output logic                     ex_we_o
  , output logic                     ex_is_branch_o
  , output logic                     ex_taken_o
  , output logic                     ex_mispredict_o
  , output logic [`BE_XLEN-1:0]      ex_redirect_pc_o
  );

  logic [`BE_XLEN-1:0]  op_b;
  logic [`BE_XLEN-1:0]  alu_result;
  logic                 is_branch;
  logic                 taken;
  logic [`BE_XLEN-1:0]  next_pc;

  // no back-pressure, anything at the queue head is taken
  assign iss_pop_o = ~iss_empty_i & ~flush_i;

  assign op_b = (iss_instr_i.op == be_pkg::op_addi) ? iss_instr_i.imm : iss_instr_i.rs2_val;

  always_comb
  begin
    case (iss_instr_i.op)
      be_pkg::op_add:  alu_result = iss_instr_i.rs1_val + op_b;
      be_pkg::op_addi: alu_result = iss_instr_i.rs1_val + op_b;
      be_pkg::op_sub:  alu_result = iss_instr_i.rs1_val - op_b;
      be_pkg::op_and:  alu_result = iss_instr_i.rs1_val & op_b;
      be_pkg::op_or:   alu_result = iss_instr_i.rs1_val | op_b;
      be_pkg::op_xor:  alu_result = iss_instr_i.rs1_val ^ op_b;
      default:         alu_result = '0;
    endcase
  end

  // branch outcome from the equality compare
  assign is_branch = be_pkg::op_is_branch(iss_instr_i.op);
  assign taken     = is_branch
                   & ((iss_instr_i.op == be_pkg::op_beq)
                      ? (iss_instr_i.rs1_val == iss_instr_i.rs2_val)
                      : (iss_instr_i.rs1_val != iss_instr_i.rs2_val));
  assign next_pc   = taken ? iss_instr_i.target : iss_instr_i.pc + `BE_XLEN'd4;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || flush_i)
      ex_valid_o <= 1'b0;
    else
      ex_valid_o <= iss_pop_o;
  end

  always_ff @(posedge clk_i)
  begin
    if (iss_pop_o)
    begin
      ex_pc_o          <= iss_instr_i.pc;
      ex_rd_o          <= iss_instr_i.rd;
      ex_result_o      <= alu_result;
      ex_we_o          <= ~is_branch;
      ex_is_branch_o   <= is_branch;
      ex_taken_o       <= taken;
      ex_mispredict_o  <= is_branch & (taken != iss_instr_i.pred_taken);
      ex_redirect_pc_o <= next_pc;
    end
  end

endmodule

//--- src/be_result_stage.sv
`timescale 1ns/10ps
`include "be_defs.svh"

module be_result_stage
  (input  logic                      clk_i
  , input  logic                     rst_n_i
  // from execute
  , input  logic                     ex_valid_i
  , input  logic [`BE_XLEN-1:0]      ex_pc_i
  , input  logic [`BE_REG_AW-1:0]    ex_rd_i
  , input  logic [`BE_XLEN-1:0]      ex_result_i
  , input  logic                     ex_we_i
  , input  logic                     ex_is_branch_i
  , input  logic                     ex_taken_i
  , input  logic                     ex_mispredict_i
  , input  logic [`BE_XLEN-1:0]      ex_redirect_pc_i
  // operand read for decode
  , input  logic [`BE_REG_AW-1:0]    rf_rs1_addr_i
  , input  logic [`BE_REG_AW-1:0]    rf_rs2_addr_i
  , output logic [`BE_XLEN-1:0]      rf_rs1_data_o
  , output logic [`BE_XLEN-1:0]      rf_rs2_data_o
  // scoreboard release
  , output logic                     wb_valid_o
  , output logic [`BE_REG_AW-1:0]    wb_rd_o
  // retire report
  , output logic                     retire_valid_o
  , output logic [`BE_XLEN-1:0]      retire_pc_o
  , output logic [`BE_REG_AW-1:0]    retire_rd_o
  , output logic                     retire_we_o
  , output logic [`BE_XLEN-1:0]      retire_data_o
  // front end redirect, also the backend flush
  , output logic                     mispredict_o
  , output logic [`BE_XLEN-1:0]      redirect_pc_o
  );

  logic [`BE_XLEN-1:0]  rf_q [`BE_NUM_REGS];
  logic                 accept;
  logic                 rf_we;

  // the instruction behind a mispredicted branch is younger, drop it
  assign accept = ex_valid_i & ~mispredict_o;
  assign rf_we  = accept & ex_we_i & (ex_rd_i != '0);

  assign rf_rs1_data_o = rf_q[rf_rs1_addr_i];
  assign rf_rs2_data_o = rf_q[rf_rs2_addr_i];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `BE_NUM_REGS; i++)
        rf_q[i] <= '0;
    end
    else if (rf_we)
      rf_q[ex_rd_i] <= ex_result_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      retire_valid_o <= 1'b0;
      wb_valid_o     <= 1'b0;
      mispredict_o   <= 1'b0;
      redirect_pc_o  <= '0;
    end
    else
    begin
      retire_valid_o <= accept;
      wb_valid_o     <= rf_we;
      mispredict_o   <= accept & ex_is_branch_i & ex_mispredict_i;
      if (accept && ex_is_branch_i && ex_mispredict_i)
        redirect_pc_o <= ex_redirect_pc_i;
    end
  end

  // branches report their outcome in the data field
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      retire_pc_o   <= ex_pc_i;
      retire_rd_o   <= ex_rd_i;
      retire_we_o   <= ex_we_i;
      retire_data_o <= ex_is_branch_i ? `BE_XLEN'(ex_taken_i) : ex_result_i;
      wb_rd_o       <= ex_rd_i;
    end
  end

endmodule

//--- src/be_top.sv
`timescale 1ns/10ps
`include "be_defs.svh"

module be_top
  (input  logic                      clk_i
  , input  logic                     rst_n_i
  // decoded instructions from the front end, credit flow
  , input  logic                     in_valid_i
  , input  be_pkg::decoded_instr_t   in_instr_i
  , output logic                     in_credit_o
  // retire report
  , output logic                     retire_valid_o
  , output logic [`BE_XLEN-1:0]      retire_pc_o
  , output logic [`BE_REG_AW-1:0]    retire_rd_o
  , output logic                     retire_we_o
  , output logic [`BE_XLEN-1:0]      retire_data_o
  // redirect to the front end
  , output logic                     mispredict_o
  , output logic [`BE_XLEN-1:0]      redirect_pc_o
  );

  // input queue <-> decode
  logic                    in_empty;
  be_pkg::decoded_instr_t  in_head;
  logic                    in_pop;

  // decode <-> register file
  logic [`BE_REG_AW-1:0]   rf_rs1_addr;
  logic [`BE_REG_AW-1:0]   rf_rs2_addr;
  logic [`BE_XLEN-1:0]     rf_rs1_data;
  logic [`BE_XLEN-1:0]     rf_rs2_data;
  logic                    wb_valid;
  logic [`BE_REG_AW-1:0]   wb_rd;

  // decode <-> issue queue <-> execute
  logic                    iss_push;
  be_pkg::issued_instr_t   iss_instr;
  logic                    iss_credit;
  logic                    iss_empty;
  be_pkg::issued_instr_t   iss_head;
  logic                    iss_pop;

  // execute -> result
  logic                    ex_valid;
  logic [`BE_XLEN-1:0]     ex_pc;
  logic [`BE_REG_AW-1:0]   ex_rd;
  logic [`BE_XLEN-1:0]     ex_result;
  logic                    ex_we;
  logic                    ex_is_branch;
  logic                    ex_taken;
  logic                    ex_mispredict;
  logic [`BE_XLEN-1:0]     ex_redirect_pc;

  be_credit_queue
    #(.PAYLOAD_T (be_pkg::decoded_instr_t)
    , .DEPTH     (`BE_IN_DEPTH)
    )
  input_queue
    (.clk_i       (clk_i)
    , .rst_n_i    (rst_n_i)
    , .flush_i    (mispredict_o)
    , .push_i     (in_valid_i)
    , .push_data_i(in_instr_i)
    , .pop_i      (in_pop)
    , .empty_o    (in_empty)
    , .pop_data_o (in_head)
    , .credit_o   (in_credit_o)
    );

  be_decode_stage decode_stage
    (.clk_i         (clk_i)
    , .rst_n_i      (rst_n_i)
    , .flush_i      (mispredict_o)
    , .in_empty_i   (in_empty)
    , .in_instr_i   (in_head)
    , .in_pop_o     (in_pop)
    , .rf_rs1_addr_o(rf_rs1_addr)
    , .rf_rs2_addr_o(rf_rs2_addr)
    , .rf_rs1_data_i(rf_rs1_data)
    , .rf_rs2_data_i(rf_rs2_data)
    , .wb_valid_i   (wb_valid)
    , .wb_rd_i      (wb_rd)
    , .iss_credit_i (iss_credit)
    , .iss_push_o   (iss_push)
    , .iss_instr_o  (iss_instr)
    );

  be_credit_queue
    #(.PAYLOAD_T (be_pkg::issued_instr_t)
    , .DEPTH     (`BE_ISS_DEPTH)
    )
  issue_queue
    (.clk_i       (clk_i)
    , .rst_n_i    (rst_n_i)
    , .flush_i    (mispredict_o)
    , .push_i     (iss_push)
    , .push_data_i(iss_instr)
    , .pop_i      (iss_pop)
    , .empty_o    (iss_empty)
    , .pop_data_o (iss_head)
    , .credit_o   (iss_credit)
    );

  be_execute_stage execute_stage
    (.clk_i            (clk_i)
    , .rst_n_i         (rst_n_i)
    , .flush_i         (mispredict_o)
    , .iss_empty_i     (iss_empty)
    , .iss_instr_i     (iss_head)
    , .iss_pop_o       (iss_pop)
    , .ex_valid_o      (ex_valid)
    , .ex_pc_o         (ex_pc)
    , .ex_rd_o         (ex_rd)
    , .ex_result_o     (ex_result)
    , .ex_we_o         (ex_we)
    , .ex_is_branch_o  (ex_is_branch)
    , .ex_taken_o      (ex_taken)
    , .ex_mispredict_o (ex_mispredict)
    , .ex_redirect_pc_o(ex_redirect_pc)
    );

  be_result_stage result_stage
    (.clk_i            (clk_i)
    , .rst_n_i         (rst_n_i)
    , .ex_valid_i      (ex_valid)
    , .ex_pc_i         (ex_pc)
    , .ex_rd_i         (ex_rd)
    , .ex_result_i     (ex_result)
    , .ex_we_i         (ex_we)
    , .ex_is_branch_i  (ex_is_branch)
    , .ex_taken_i      (ex_taken)
    , .ex_mispredict_i (ex_mispredict)
    , .ex_redirect_pc_i(ex_redirect_pc)
    , .rf_rs1_addr_i   (rf_rs1_addr)
    , .rf_rs2_addr_i   (rf_rs2_addr)
    , .rf_rs1_data_o   (rf_rs1_data)
    , .rf_rs2_data_o   (rf_rs2_data)
    , .wb_valid_o      (wb_valid)
    , .wb_rd_o         (wb_rd)
    , .retire_valid_o  (retire_valid_o)
    , .retire_pc_o     (retire_pc_o)
    , .retire_rd_o     (retire_rd_o)
    , .retire_we_o     (retire_we_o)
    , .retire_data_o   (retire_data_o)
    , .mispredict_o    (mispredict_o)
    , .redirect_pc_o   (redirect_pc_o)
    );

endmodule

//--- dv/be_tb_clk.sv
`timescale 1ns/10ps

module be_tb_clk
  #(parameter int PERIOD_NS    = 8
  , parameter int RESET_CYCLES = 10
  )
  (output logic clk_o
  , output logic rst_n_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // released on a rising edge, the DUT sees it one cycle later
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- dv/be_assert.sv
`timescale 1ns/10ps
`include "be_defs.svh"

module be_assert
  (input  logic                  clk_i
  , input logic                  rst_n_i
  , input logic                  in_valid_i
  , input logic                  in_credit_i
  , input logic                  retire_valid_i
  , input logic                  mispredict_i
  , input logic [`BE_XLEN-1:0]   redirect_pc_i
  );

  localparam int OW = $clog2(`BE_IN_DEPTH) + 2;

  logic [OW-1:0]  outstanding_q;
  int             fail_reset = 0;
  int             fail_credit = 0;
  int             fail_flush = 0;
  int             fail_align = 0;
  int             fail_total;

  // entries the input queue holds for the sender, a flush drops them all
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || mispredict_i)
      outstanding_q <= '0;
    else
      outstanding_q <= outstanding_q + OW'(in_valid_i) - OW'(in_credit_i);
  end

  assign fail_total = fail_reset + fail_credit + fail_flush + fail_align;

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> (!retire_valid_i && !mispredict_i && !in_credit_i))
  else
  begin
    $error("retire, mispredict or credit active right after reset");
    fail_reset++;
  end

  credit_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding_q <= OW'(`BE_IN_DEPTH))
  else
  begin
    $error("input queue holds more entries than the sender has credits");
    fail_credit++;
  end

  flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mispredict_i |=> !retire_valid_i)
  else
  begin
    $error("instruction retired in the cycle after a mispredict");
    fail_flush++;
  end

  redirect_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mispredict_i |-> (redirect_pc_i[1:0] == 2'b00))
  else
  begin
    $error("redirect pc is not word aligned");
    fail_align++;
  end

endmodule

//--- dv/be_tb.sv
`timescale 1ns/10ps
`include "be_defs.svh"

module be_tb;

  localparam int CLK_PERIOD      = 8;
  localparam int N_RANDOM        = 60;
  localparam int N_CHAIN         = 24;
  localparam int N_ZERO          = 12;
  localparam int N_BURST         = 24;
  localparam int N_MISPREDICT    = 30;
  localparam int N_PREDICTED     = 24;
  localparam int TOTAL_INSTR     = N_RANDOM + N_CHAIN + N_ZERO + N_BURST + N_MISPREDICT
                                 + N_PREDICTED;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 200 + 500;

  logic                    clk;
  logic                    rst_n;
  logic                    in_valid;
  be_pkg::decoded_instr_t  in_instr;
  logic                    in_credit;
  logic                    retire_valid;
  logic [`BE_XLEN-1:0]     retire_pc;
  logic [`BE_REG_AW-1:0]   retire_rd;
  logic                    retire_we;
  logic [`BE_XLEN-1:0]     retire_data;
  logic                    mispredict;
  logic [`BE_XLEN-1:0]     redirect_pc;

  // sent but not yet retired in send order
  be_pkg::decoded_instr_t  pending [$];
  logic [`BE_XLEN-1:0]     shadow [`BE_NUM_REGS];
  logic [`BE_XLEN-1:0]     pc_next;
  integer                  seed;
  string                   test_name;
  int credits;
  int credit_pulses;
  int pushes;
  int retired;
  int mispredicts;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;

  be_tb_clk #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) clk_gen
    (.clk_o   (clk)
    , .rst_n_o(rst_n)
    );

  be_top dut_i
    (.clk_i          (clk)
    , .rst_n_i       (rst_n)
    , .in_valid_i    (in_valid)
    , .in_instr_i    (in_instr)
    , .in_credit_o   (in_credit)
    , .retire_valid_o(retire_valid)
    , .retire_pc_o   (retire_pc)
    , .retire_rd_o   (retire_rd)
    , .retire_we_o   (retire_we)
    , .retire_data_o (retire_data)
    , .mispredict_o  (mispredict)
    , .redirect_pc_o (redirect_pc)
    );

  bind be_top be_assert protocol_checks
    (.clk_i          (clk_i)
    , .rst_n_i       (rst_n_i)
    , .in_valid_i    (in_valid_i)
    , .in_credit_i   (in_credit_o)
    , .retire_valid_i(retire_valid_o)
    , .mispredict_i  (mispredict_o)
    , .redirect_pc_i (redirect_pc_o)
    );

  function automatic logic [31:0] alu_model(input be_pkg::be_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      be_pkg::op_add, be_pkg::op_addi: return a + b;
      be_pkg::op_sub: return a - b;
      be_pkg::op_and: return a & b;
      be_pkg::op_or:  return a | b;
      be_pkg::op_xor: return a ^ b;
      default:        return 32'h0;
    endcase
  endfunction

  task automatic record_error();
    errors++;
    test_errors++;
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      record_error();
    end
  endtask

  // outputs read at the rising edge still hold the values of the cycle before it
  task automatic check_outputs();
    be_pkg::decoded_instr_t ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_data;
    logic is_branch;
    logic taken;
    logic exp_misp;
    if (in_credit)
    begin
      credits++;
      credit_pulses++;
    end
    if (retire_valid)
    begin
      assert (pending.size() != 0)
      else
      begin
        $display("test %s: retire at pc %h with nothing outstanding", test_name, retire_pc);
        record_error();
      end
      if (pending.size() != 0)
      begin
        ins = pending.pop_front();
        a = shadow[ins.rs1];
        b = (ins.op == be_pkg::op_addi) ? ins.imm : shadow[ins.rs2];
        is_branch = (ins.op == be_pkg::op_beq) || (ins.op == be_pkg::op_bne);
        taken = (ins.op == be_pkg::op_beq) ? (a == b) : (a != b);
        exp_misp = is_branch && (taken != ins.pred_taken);
        exp_data = is_branch ? {31'b0, taken} : alu_model(ins.op, a, b);
        compare_value("pc", ins.pc, retire_pc);
        compare_value("rd", 32'(ins.rd), 32'(retire_rd));
        compare_value("write enable", 32'(!is_branch), 32'(retire_we));
        compare_value("data", exp_data, retire_data);
        compare_value("mispredict", 32'(exp_misp), 32'(mispredict));
        if (exp_misp)
          compare_value("redirect pc", taken ? ins.target : ins.pc + 32'd4, redirect_pc);
        if (!is_branch && ins.rd != '0)
          shadow[ins.rd] = exp_data;
        retired++;
      end
    end
    else
    begin
      assert (!mispredict)
      else
      begin
        $display("test %s: mispredict raised with no branch retiring", test_name);
        record_error();
      end
    end
    // everything younger than the branch is gone and credits come back in full
    if (mispredict)
    begin
      credits = `BE_IN_DEPTH;
      pending.delete();
      mispredicts++;
    end
  endtask

  task automatic make_instr(input int kind, input int idx, output be_pkg::decoded_instr_t ins);
    logic [31:0] r;
    logic [2:0] op_pick;
    r = $random(seed);
    op_pick = r[11:9];
    if (op_pick > 3'd5)
      op_pick = op_pick - 3'd6;
    ins = '0;
    ins.op = be_pkg::be_op_e'(op_pick);
    ins.rd = r[2:0];
    ins.rs1 = r[5:3];
    ins.rs2 = r[8:6];
    ins.imm = $random(seed);
    ins.pc = pc_next;
    pc_next = pc_next + 32'd4;
    case (kind)
      1:
      begin
        // each result feeds the next instruction
        ins.rd = 3'(1 + idx % 7);
        ins.rs1 = 3'(1 + (idx + 6) % 7);
      end
      2:
      begin
        if (idx % 2 == 0)
          ins.rd = '0;
        else
        begin
          ins.rs1 = '0;
          ins.rs2 = '0;
        end
      end
      4, 5:
      begin
        // equal sources fix the outcome
        // kind 4 predicts the other way
        if (idx % 3 == 2)
        begin
          ins.op = r[12] ? be_pkg::op_beq : be_pkg::op_bne;
          ins.rs2 = ins.rs1;
          ins.pred_taken = (ins.op == be_pkg::op_beq) ^ (kind == 4);
          ins.target = ins.imm & 32'hffff_fffc;
        end
      end
      default:
      begin
      end
    endcase
  endtask

  function automatic logic send_now(input int kind);
    if (kind == 1 || kind == 3)
      return 1'b1;
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic run_test(input int kind, input string name, input int count);
    be_pkg::decoded_instr_t ins;
    int sent;
    int idle_left;
    test_name = name;
    test_errors = 0;
    credit_pulses = 0;
    pushes = 0;
    retired = 0;
    mispredicts = 0;
    sent = 0;
    idle_left = 0;
    while (sent < count || pending.size() != 0)
    begin
      @(posedge clk);
      check_outputs();
      if (sent < count && credits > 0 && idle_left == 0 && send_now(kind))
      begin
        make_instr(kind, sent, ins);
        in_valid <= 1'b1;
        in_instr <= ins;
        pending.push_back(ins);
        credits--;
        pushes++;
        sent++;
        // burst test spends all credits and then goes quiet
        if (kind == 3 && sent % `BE_IN_DEPTH == 0)
          idle_left = 16;
      end
      else
      begin
        in_valid <= 1'b0;
        if (idle_left > 0)
          idle_left--;
      end
    end
    compare_value("credits", `BE_IN_DEPTH, credits);
    if (mispredicts == 0)
      compare_value("credit pulses", pushes, credit_pulses);
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("test %s done: %0d sent, %0d retired, %0d mispredicts, %0d errors",
             name, sent, retired, mispredicts, test_errors);
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    seed = 77;
    in_valid = 1'b0;
    in_instr = '0;
    credits = `BE_IN_DEPTH;
    pc_next = 32'h100;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < `BE_NUM_REGS; i++)
      shadow[i] = '0;
    while (rst_n !== 1'b1)
      @(posedge clk);
    run_test(0, "random_alu", N_RANDOM);
    run_test(1, "dependent_chain", N_CHAIN);
    run_test(2, "reg_zero", N_ZERO);
    run_test(3, "credit_burst", N_BURST);
    run_test(4, "mispredict", N_MISPREDICT);
    run_test(5, "predicted_branch", N_PREDICTED);
    repeat (4) @(posedge clk);
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut_i.protocol_checks.fail_total);
    if (errors == 0 && dut_i.protocol_checks.fail_total == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
src/be_pkg.sv
src/be_credit_queue.sv
src/be_decode_stage.sv
src/be_execute_stage.sv
src/be_result_stage.sv
src/be_top.sv
dv/be_tb_clk.sv
dv/be_assert.sv
dv/be_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= be_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===

SRCS    := $(wildcard src/*.sv dv/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
